//--- logic/mecobo_pkg.sv
/*
 * mecobo shared definitions
 * bus widths, per-pin register map and waveform mode codes
 */
`default_nettype none

package mecobo_pkg;

  // external bus interface
  localparam int ADDR_W = 21;
  localparam int DATA_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // pin blocks start here, one block of PIN_STRIDE words per pin
  localparam addr_t PIN_BASE   = 21'h32;
  localparam int    PIN_STRIDE = 6;

  // word offsets inside one pin block
  localparam logic [2:0] REG_MODE   = 3'd0;
  localparam logic [2:0] REG_PERIOD = 3'd1; // in ticks
  localparam logic [2:0] REG_DUTY   = 3'd2; // pwm high count
  localparam logic [2:0] REG_PHASE  = 3'd3; // counter start value
  localparam logic [2:0] REG_TICK   = 3'd4; // read only
  localparam logic [2:0] REG_LAST   = 3'd5;

  // waveform modes, anything else drives the pin low
  localparam data_t MODE_OFF    = 16'd0;
  localparam data_t MODE_SQUARE = 16'd1;
  localparam data_t MODE_PWM    = 16'd4;

endpackage

`default_nettype wire

//--- logic/ebi_bus_fsm.sv
/*
 * ebi bus controller
 * turns the host's chip select and strobe levels into one-cycle strobes,
 * merges the pin read words into the registered read data
 */
`timescale 1ns/10ps
`default_nettype none

module ebi_bus_fsm
  import mecobo_pkg::*;
#(
  parameter int NUM_PINS = 8
) (
  input  wire logic                       sys_clk,
  input  wire logic                       reset,
  input  wire logic                       ebi_cs_n,
  input  wire logic                       ebi_wr_n,
  input  wire logic                       ebi_rd_n,
  input  wire addr_t                      ebi_addr,
  input  wire data_t                      ebi_wr_data,
  input  wire logic [NUM_PINS*DATA_W-1:0] pin_rd_words,
  output logic                            wr_stb,
  output logic                            rd_stb,
  output addr_t                           bus_addr,
  output data_t                           bus_data,
  output data_t                           ebi_rd_data,
  output logic                            ebi_rd_valid
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_READ,
    S_RELEASE
  } state_t;

  state_t state;
  logic   access_start;
  logic   access_done;
  data_t  rd_merge;

  // host started an access, write wins if both strobes are low
  assign access_start = !ebi_cs_n && (!ebi_wr_n || !ebi_rd_n);
  assign access_done  = ebi_cs_n && ebi_wr_n && ebi_rd_n;

  // unaddressed pins return zero, so a plain or is enough
  always_comb begin
    rd_merge = '0;
    for (int i = 0; i < NUM_PINS; i++) begin
      rd_merge = rd_merge | pin_rd_words[i*DATA_W +: DATA_W];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state        <= S_IDLE;
      wr_stb       <= 1'b0;
      rd_stb       <= 1'b0;
      ebi_rd_valid <= 1'b0;
    end else begin
      wr_stb       <= 1'b0;
      rd_stb       <= 1'b0;
      ebi_rd_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (access_start && !ebi_wr_n) begin
            wr_stb <= 1'b1;
            state  <= S_WRITE;
          end else if (access_start) begin
            rd_stb <= 1'b1;
            state  <= S_READ;
          end
        end
        S_WRITE: state <= S_RELEASE; // pins stored the word on this edge
        S_READ: begin
          if (!rd_stb) begin // pin words registered one edge ago
            ebi_rd_valid <= 1'b1;
            state        <= S_RELEASE;
          end
        end
        S_RELEASE: begin
          // hold off until the host ends the access
          if (access_done) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // address, write data and read data
  always_ff @(posedge sys_clk) begin
    if (state == S_IDLE && access_start) begin
      bus_addr <= ebi_addr;
      bus_data <= ebi_wr_data;
    end
    if (state == S_READ && !rd_stb) begin
      ebi_rd_data <= rd_merge;
    end
  end

endmodule

`default_nettype wire

//--- logic/tick_timer.sv
/*
 * waveform tick prescaler and board status
 * one-cycle tick every TICK_DIV clocks, heartbeat on the leds, fpga_ready
 */
`timescale 1ns/10ps
`default_nettype none

module tick_timer #(
  parameter int TICK_DIV = 100,
  parameter int HB_W     = 24
) (
  input  wire logic       sys_clk,
  input  wire logic       reset,
  output logic            tick,
  output logic [3:0]      led,
  output logic            fpga_ready
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [CNT_W-1:0] div_cnt;
  logic [HB_W-1:0]  hb_cnt;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      div_cnt <= CNT_W'(TICK_DIV - 1);
      tick    <= 1'b0;
    end else if (div_cnt == '0) begin
      div_cnt <= CNT_W'(TICK_DIV - 1); // reload and fire
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt - 1'b1;
      tick    <= 1'b0;
    end
  end

  // free running heartbeat
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      hb_cnt     <= '0;
      fpga_ready <= 1'b0;
    end else begin
      hb_cnt     <= hb_cnt + 1'b1;
      fpga_ready <= 1'b1; // up on first edge out of reset
    end
  end

  assign led = hb_cnt[HB_W-1 -: 4];

endmodule

`default_nettype wire

//--- logic/pin_regs.sv
/*
 * configuration words of one output pin
 * decodes its address block, stores host writes and returns read words
 */
`timescale 1ns/10ps
`default_nettype none

module pin_regs
  import mecobo_pkg::*;
#(
  parameter int POSITION = 0
) (
  input  wire logic  sys_clk,
  input  wire logic  reset,
  input  wire logic  wr_stb,
  input  wire logic  rd_stb,
  input  wire addr_t bus_addr,
  input  wire data_t bus_data,
  input  wire data_t cur_tick,
  output data_t      rd_word,
  output data_t      mode,
  output data_t      period,
  output data_t      duty,
  output data_t      phase,
  output logic       cfg_load
);

  localparam addr_t BLK_BASE = PIN_BASE + addr_t'(POSITION * PIN_STRIDE);

  addr_t      rel_addr;
  logic       hit;
  logic [2:0] offset;
  data_t      last_word;
  data_t      rd_sel;

  // below the base wraps to a large value and misses too
  assign rel_addr = bus_addr - BLK_BASE;
  assign hit      = rel_addr < addr_t'(PIN_STRIDE);
  assign offset   = rel_addr[2:0];

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      mode      <= '0;
      period    <= '0;
      duty      <= '0;
      phase     <= '0;
      last_word <= '0;
      cfg_load  <= 1'b0;
    end else begin
      cfg_load <= 1'b0;
      if (wr_stb && hit) begin
        case (offset)
          REG_MODE: begin
            mode      <= bus_data;
            last_word <= bus_data;
            cfg_load  <= 1'b1;
          end
          REG_PERIOD: begin
            period    <= bus_data;
            last_word <= bus_data;
            cfg_load  <= 1'b1;
          end
          REG_DUTY: begin
            duty      <= bus_data; // no counter reload for duty
            last_word <= bus_data;
          end
          REG_PHASE: begin
            phase     <= bus_data;
            last_word <= bus_data;
            cfg_load  <= 1'b1;
          end
          REG_LAST: last_word <= bus_data;
          default: ; // tick word is read only
        endcase
      end
    end
  end

  always_comb begin
    case (offset)
      REG_MODE:   rd_sel = mode;
      REG_PERIOD: rd_sel = period;
      REG_DUTY:   rd_sel = duty;
      REG_PHASE:  rd_sel = phase;
      REG_TICK:   rd_sel = cur_tick;
      REG_LAST:   rd_sel = last_word;
      default:    rd_sel = '0;
    endcase
  end

  // zero unless this pin was read, so the bus side can or all pins
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      rd_word <= '0;
    end else begin
      rd_word <= (rd_stb && hit) ? rd_sel : '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/wave_gen.sv
/*
 * waveform generator of one pin
 * tick counter with phase load, square or pwm level derived from it
 */
`timescale 1ns/10ps
`default_nettype none

module wave_gen
  import mecobo_pkg::*;
(
  input  wire logic  sys_clk,
  input  wire logic  reset,
  input  wire logic  tick,
  input  wire logic  cfg_load,
  input  wire data_t mode,
  input  wire data_t period,
  input  wire data_t duty,
  input  wire data_t phase,
  output data_t      cur_tick,
  output logic       pin
);

  data_t cnt;
  data_t half_period;
  logic  period_zero;

  assign period_zero = (period == '0);
  assign half_period = period >> 1; // rounded down

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (period_zero) begin
      cnt <= '0; // stalled
    end else if (cfg_load) begin
      // out of range phase starts from zero
      cnt <= (phase < period) ? phase : '0;
    end else if (tick) begin
      if (cnt >= period - 1'b1) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  assign cur_tick = cnt;

  always_comb begin
    case (mode)
      MODE_SQUARE: pin = (cnt < half_period);
      MODE_PWM:    pin = (cnt < duty);
      MODE_OFF:    pin = 1'b0;
      default:     pin = 1'b0; // unsupported shapes stay low
    endcase
  end

endmodule

`default_nettype wire

//--- logic/mecobo_core.sv
/*
 * mecobo board-control core
 * ebi bus controller, tick timer and one register bank plus waveform per pin
 */
`timescale 1ns/10ps
`default_nettype none

module mecobo_core
  import mecobo_pkg::*;
#(
  parameter int NUM_PINS = 8,
  parameter int TICK_DIV = 100,
  parameter int HB_W     = 24
) (
  input  wire logic                sys_clk,
  input  wire logic                reset,
  input  wire logic                ebi_cs_n,
  input  wire logic                ebi_wr_n,
  input  wire logic                ebi_rd_n,
  input  wire addr_t               ebi_addr,
  input  wire data_t               ebi_wr_data,
  output data_t                    ebi_rd_data,
  output logic                     ebi_rd_valid,
  output logic [NUM_PINS-1:0]      pins,
  output logic [3:0]               led,
  output logic                     fpga_ready
);

  logic                       wr_stb;
  logic                       rd_stb;
  addr_t                      bus_addr;
  data_t                      bus_data;
  logic [NUM_PINS*DATA_W-1:0] pin_rd_words;
  logic                       tick;

  ebi_bus_fsm #(
    .NUM_PINS(NUM_PINS)
  ) u_bus (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .ebi_cs_n     (ebi_cs_n),
    .ebi_wr_n     (ebi_wr_n),
    .ebi_rd_n     (ebi_rd_n),
    .ebi_addr     (ebi_addr),
    .ebi_wr_data  (ebi_wr_data),
    .pin_rd_words (pin_rd_words),
    .wr_stb       (wr_stb),
    .rd_stb       (rd_stb),
    .bus_addr     (bus_addr),
    .bus_data     (bus_data),
    .ebi_rd_data  (ebi_rd_data),
    .ebi_rd_valid (ebi_rd_valid)
  );

  tick_timer #(
    .TICK_DIV(TICK_DIV),
    .HB_W    (HB_W)
  ) u_timer (
    .sys_clk    (sys_clk),
    .reset      (reset),
    .tick       (tick),
    .led        (led),
    .fpga_ready (fpga_ready)
  );

  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
    data_t mode;
    data_t period;
    data_t duty;
    data_t phase;
    data_t cur_tick;
    logic  cfg_load;

    pin_regs #(
      .POSITION(i)
    ) u_regs (
      .sys_clk  (sys_clk),
      .reset    (reset),
      .wr_stb   (wr_stb),
      .rd_stb   (rd_stb),
      .bus_addr (bus_addr),
      .bus_data (bus_data),
      .cur_tick (cur_tick),
      .rd_word  (pin_rd_words[i*DATA_W +: DATA_W]),
      .mode     (mode),
      .period   (period),
      .duty     (duty),
      .phase    (phase),
      .cfg_load (cfg_load)
    );

    wave_gen u_wave (
      .sys_clk  (sys_clk),
      .reset    (reset),
      .tick     (tick),
      .cfg_load (cfg_load),
      .mode     (mode),
      .period   (period),
      .duty     (duty),
      .phase    (phase),
      .cur_tick (cur_tick),
      .pin      (pins[i])
    );
  end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
/*
 * testbench clock and reset generator
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic sys_clk,
  output logic reset
);

  initial begin
    sys_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) sys_clk = ~sys_clk;
    end
  end

  // held over RESET_CYCLES rising edges, dropped on a falling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    @(negedge sys_clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/mecobo_tb.sv
/*
 * mecobo_core testbench
 * random ebi traffic checked every cycle against a cycle model of the core
 */
`timescale 1ns/10ps
`default_nettype none

module mecobo_tb
  import mecobo_pkg::*;
();

  localparam int NUM_PINS      = 4;
  localparam int TICK_DIV      = 4;
  localparam int HB_W          = 8;
  localparam int RAND_WRITES   = 8;
  localparam int OUTSIDE_READS = 16;
  localparam int WAVE_ROUNDS   = 4;
  localparam int TICK_READS    = 8;
  localparam int BOTH_LOW      = 8;

  // every access takes 5 cycles, idle gaps counted at their maximum
  localparam int ACCESSES = NUM_PINS * (RAND_WRITES + PIN_STRIDE) + OUTSIDE_READS
                          + WAVE_ROUNDS * (NUM_PINS * 4 + TICK_READS)
                          + NUM_PINS * 3 + 3 + BOTH_LOW * 2;
  localparam int IDLE_MAX    = 5 + 3 + WAVE_ROUNDS * TICK_READS * 7 + 40 + 20;
  localparam int CYCLE_LIMIT = 5 * ACCESSES + IDLE_MAX + 2000;

  // model bus states
  localparam int ST_IDLE    = 0;
  localparam int ST_WRITE   = 1;
  localparam int ST_READ_A  = 2;
  localparam int ST_READ_B  = 3;
  localparam int ST_RELEASE = 4;

  logic                sys_clk;
  logic                reset;
  logic                ebi_cs_n;
  logic                ebi_wr_n;
  logic                ebi_rd_n;
  addr_t               ebi_addr;
  data_t               ebi_wr_data;
  data_t               ebi_rd_data;
  logic                ebi_rd_valid;
  logic [NUM_PINS-1:0] pins;
  logic [3:0]          led;
  logic                fpga_ready;

  integer seed        = 32'h995fe903;
  int     cycle_count = 0;

  // model state, always the value just before the next rising edge
  logic            model_live = 1'b0;
  int              edge_count;
  logic            m_tick;
  logic [HB_W-1:0] m_hb;
  logic            m_ready;
  int              m_state;
  logic            m_wr_stb;
  logic            m_rd_stb;
  addr_t           m_addr;
  data_t           m_data;
  data_t           m_rd_word;
  data_t           m_rd_data;
  logic            m_valid;
  data_t           m_mode [NUM_PINS];
  data_t           m_period [NUM_PINS];
  data_t           m_duty [NUM_PINS];
  data_t           m_phase [NUM_PINS];
  data_t           m_last [NUM_PINS];
  data_t           m_cnt [NUM_PINS];
  logic            m_load [NUM_PINS];

  tb_clock #(
    .PERIOD_NS   (8),
    .RESET_CYCLES(5)
  ) clk_gen (
    .sys_clk (sys_clk),
    .reset   (reset)
  );

  mecobo_core #(
    .NUM_PINS(NUM_PINS),
    .TICK_DIV(TICK_DIV),
    .HB_W    (HB_W)
  ) dut0 (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .ebi_cs_n     (ebi_cs_n),
    .ebi_wr_n     (ebi_wr_n),
    .ebi_rd_n     (ebi_rd_n),
    .ebi_addr     (ebi_addr),
    .ebi_wr_data  (ebi_wr_data),
    .ebi_rd_data  (ebi_rd_data),
    .ebi_rd_valid (ebi_rd_valid),
    .pins         (pins),
    .led          (led),
    .fpga_ready   (fpga_ready)
  );

  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic addr_t reg_addr(input int pin, input int off);
    return PIN_BASE + addr_t'(pin * PIN_STRIDE + off);
  endfunction

  // -1 when the address hits no pin block
  function automatic int pin_of(input addr_t a);
    int rel;
    rel = int'(a) - int'(PIN_BASE);
    if (rel < 0 || rel >= NUM_PINS * PIN_STRIDE) begin
      return -1;
    end
    return rel / PIN_STRIDE;
  endfunction

  function automatic int offset_of(input addr_t a);
    return (int'(a) - int'(PIN_BASE)) % PIN_STRIDE;
  endfunction

  function automatic data_t model_read(input addr_t a);
    int p;
    p = pin_of(a);
    if (p < 0) begin
      return '0;
    end
    case (offset_of(a))
      0:       return m_mode[p];
      1:       return m_period[p];
      2:       return m_duty[p];
      3:       return m_phase[p];
      4:       return m_cnt[p];
      default: return m_last[p];
    endcase
  endfunction

  function automatic logic level_of(input int p);
    if (m_mode[p] == MODE_SQUARE) begin
      return m_cnt[p] < m_period[p] / 16'd2;
    end
    if (m_mode[p] == MODE_PWM) begin
      return m_cnt[p] < m_duty[p];
    end
    return 1'b0;
  endfunction

  task automatic report_error(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
    $display("Done: errors found");
  endtask

  task automatic check_outputs();
    logic [NUM_PINS-1:0] exp_pins;
    for (int p = 0; p < NUM_PINS; p++) begin
      exp_pins[p] = level_of(p);
    end
    assert (pins === exp_pins) else begin
      report_error("pins", 32'(pins), 32'(exp_pins));
      $fatal(1, "pin level mismatch");
    end
    assert (ebi_rd_valid === m_valid) else begin
      report_error("ebi_rd_valid", 32'(ebi_rd_valid), 32'(m_valid));
      $fatal(1, "read valid mismatch");
    end
    if (m_valid) begin
      assert (ebi_rd_data === m_rd_data) else begin
        report_error("ebi_rd_data", 32'(ebi_rd_data), 32'(m_rd_data));
        $fatal(1, "read data mismatch");
      end
    end
    assert (led === m_hb[HB_W-1 -: 4]) else begin
      report_error("led", 32'(led), 32'(m_hb[HB_W-1 -: 4]));
      $fatal(1, "heartbeat mismatch");
    end
    assert (fpga_ready === m_ready) else begin
      report_error("fpga_ready", 32'(fpga_ready), 32'(m_ready));
      $fatal(1, "ready flag mismatch");
    end
  endtask

  task automatic reset_model();
    model_live = 1'b1;
    edge_count = 0;
    m_tick     = 1'b0;
    m_hb       = '0;
    m_ready    = 1'b0;
    m_state    = ST_IDLE;
    m_wr_stb   = 1'b0;
    m_rd_stb   = 1'b0;
    m_addr     = '0;
    m_rd_word  = '0;
    m_valid    = 1'b0;
    for (int p = 0; p < NUM_PINS; p++) begin
      m_mode[p]   = '0;
      m_period[p] = '0;
      m_duty[p]   = '0;
      m_phase[p]  = '0;
      m_last[p]   = '0;
      m_cnt[p]    = '0;
      m_load[p]   = 1'b0;
    end
  endtask

  // one rising edge, each step reads the values from before the edge
  task automatic advance_model();
    int   p;
    int   off;
    logic start;
    m_valid = (m_state == ST_READ_B); // two edges after the read began
    if (m_valid) begin
      m_rd_data = m_rd_word;
    end
    m_rd_word = m_rd_stb ? model_read(m_addr) : '0;
    for (int i = 0; i < NUM_PINS; i++) begin
      if (m_period[i] == '0) begin
        m_cnt[i] = '0;
      end else if (m_load[i]) begin
        m_cnt[i] = (m_phase[i] < m_period[i]) ? m_phase[i] : '0;
      end else if (m_tick) begin
        m_cnt[i] = (int'(m_cnt[i]) + 1 >= int'(m_period[i])) ? '0 : m_cnt[i] + 16'd1;
      end
      m_load[i] = 1'b0;
    end
    p = pin_of(m_addr);
    if (m_wr_stb && p >= 0) begin
      off = offset_of(m_addr);
      case (off)
        0:       m_mode[p] = m_data;
        1:       m_period[p] = m_data;
        2:       m_duty[p] = m_data;
        3:       m_phase[p] = m_data;
        default: ;
      endcase
      if (off != 4) begin
        m_last[p] = m_data; // tick word is read only
      end
      m_load[p] = (off == 0 || off == 1 || off == 3);
    end
    edge_count++;
    m_tick = (edge_count % TICK_DIV == 0);
    start    = !ebi_cs_n && (!ebi_wr_n || !ebi_rd_n);
    m_wr_stb = 1'b0;
    m_rd_stb = 1'b0;
    case (m_state)
      ST_IDLE: begin
        if (start) begin
          m_addr = ebi_addr;
          m_data = ebi_wr_data;
          if (!ebi_wr_n) begin
            m_wr_stb = 1'b1;
            m_state  = ST_WRITE;
          end else begin
            m_rd_stb = 1'b1;
            m_state  = ST_READ_A;
          end
        end
      end
      ST_WRITE:  m_state = ST_RELEASE;
      ST_READ_A: m_state = ST_READ_B;
      ST_READ_B: m_state = ST_RELEASE;
      default: begin
        if (ebi_cs_n && ebi_wr_n && ebi_rd_n) begin
          m_state = ST_IDLE;
        end
      end
    endcase
    m_hb    = m_hb + HB_W'(1);
    m_ready = 1'b1;
  endtask

  always @(posedge sys_clk) begin
    if (model_live) begin
      check_outputs();
    end
    if (reset) begin
      reset_model();
    end else begin
      advance_model();
    end
  end

  always @(posedge sys_clk) begin
    cycle_count++;
    assert (cycle_count < CYCLE_LIMIT) else begin
      $display("Error: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  // strobe low for three edges, then high for two
  task automatic bus_access(input logic do_wr, input logic do_rd, input addr_t a,
                            input data_t d);
    @(negedge sys_clk);
    ebi_addr    = a;
    ebi_wr_data = d;
    ebi_cs_n    = 1'b0;
    ebi_wr_n    = !do_wr;
    ebi_rd_n    = !do_rd;
    repeat (3) @(negedge sys_clk);
    ebi_cs_n = 1'b1;
    ebi_wr_n = 1'b1;
    ebi_rd_n = 1'b1;
    @(negedge sys_clk);
  endtask

  task automatic write_reg(input int pin, input int off, input data_t d);
    bus_access(1'b1, 1'b0, reg_addr(pin, off), d);
  endtask

  task automatic read_reg(input int pin, input int off);
    bus_access(1'b0, 1'b1, reg_addr(pin, off), '0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge sys_clk);
  endtask

  initial begin
    int unsigned per;
    int          code;
    int          pin;
    int          off;
    addr_t       a;
    ebi_cs_n    = 1'b1;
    ebi_wr_n    = 1'b1;
    ebi_rd_n    = 1'b1;
    ebi_addr    = '0;
    ebi_wr_data = '0;
    @(negedge reset);
    idle_cycles(3);

    // random writes at random offsets, tick word included, then read all back
    for (pin = 0; pin < NUM_PINS; pin++) begin
      for (int i = 0; i < RAND_WRITES; i++) begin
        write_reg(pin, int'(rand_below(PIN_STRIDE)), data_t'($random(seed)));
      end
      for (off = 0; off < PIN_STRIDE; off++) begin
        read_reg(pin, off);
      end
    end

    // outside every pin block
    for (int i = 0; i < OUTSIDE_READS; i++) begin
      if (i == 0) begin
        a = PIN_BASE - addr_t'(1);
      end else if (i == 1) begin
        a = reg_addr(NUM_PINS, 0); // first word past the last pin
      end else if (i % 2 == 0) begin
        a = addr_t'(rand_below(int'(PIN_BASE)));
      end else begin
        a = reg_addr(NUM_PINS, 0) + addr_t'(rand_below(32'h1f_0000));
      end
      bus_access(1'b0, 1'b1, a, '0);
    end

    // square and pwm with small periods, tick words read while running
    for (int r = 0; r < WAVE_ROUNDS; r++) begin
      for (pin = 0; pin < NUM_PINS; pin++) begin
        per = 1 + rand_below(12);
        write_reg(pin, int'(REG_PERIOD), data_t'(per));
        write_reg(pin, int'(REG_DUTY), data_t'(rand_below(per + 2)));
        write_reg(pin, int'(REG_PHASE), data_t'(rand_below(per + 3)));
        write_reg(pin, int'(REG_MODE), (rand_below(2) == 0) ? MODE_SQUARE : MODE_PWM);
      end
      for (int i = 0; i < TICK_READS; i++) begin
        idle_cycles(int'(rand_below(8)));
        read_reg(int'(rand_below(NUM_PINS)), int'(REG_TICK));
      end
    end

    // unsupported modes, and square with a zero period
    for (pin = 0; pin < NUM_PINS; pin++) begin
      code = int'(rand_below(16));
      if (code == 1 || code == 4) begin
        code = code + 1;
      end
      write_reg(pin, int'(REG_PERIOD), data_t'(2 + rand_below(8)));
      write_reg(pin, int'(REG_DUTY), 16'hffff); // pwm would be high
      write_reg(pin, int'(REG_MODE), data_t'(code));
    end
    write_reg(0, int'(REG_PERIOD), '0);
    write_reg(0, int'(REG_MODE), MODE_SQUARE);
    idle_cycles(40);
    assert (pins === '0) else begin
      report_error("pins", 32'(pins), 32'd0);
      $fatal(1, "pins not low in off modes");
    end
    read_reg(0, int'(REG_TICK)); // counter held at zero

    // both strobes low acts as a write
    for (int i = 0; i < BOTH_LOW; i++) begin
      pin = int'(rand_below(NUM_PINS));
      off = int'(rand_below(5));
      if (off == 4) begin
        off = 5;
      end
      bus_access(1'b1, 1'b1, reg_addr(pin, off), data_t'($random(seed)));
      read_reg(pin, off);
    end

    idle_cycles(20);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- mecobo_core.f
logic/mecobo_pkg.sv
logic/ebi_bus_fsm.sv
logic/tick_timer.sv
logic/pin_regs.sv
logic/wave_gen.sv
logic/mecobo_core.sv
dv/tb_clock.sv
dv/mecobo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the mecobo_core testbench with verilator and run it
# a failing run ends in $fatal, which makes the simulation exit non-zero
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module mecobo_tb \
  -f mecobo_core.f \
  -Mdir build/obj_dir \
  -o mecobo_sim

./build/obj_dir/mecobo_sim
